// ==== filelist.f ====
rtl/rv_isa_pkg.sv
rtl/id_ctrl_pkg.sv
rtl/id_decoder.sv
rtl/id_operand_mux.sv
rtl/id_ex_fsm.sv
rtl/id_stage.sv
verif/id_stage_properties.sv
verif/tb_id_stage.sv

// ==== rtl/id_ctrl_pkg.sv ====
/*
 * Decode-stage control types: ALU operation, operand selects,
 * LSU access size and the ID-EX FSM state
 */
package id_ctrl_pkg;

  // Operations carried out by the EX stage ALU
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLT,
    ALU_SLTU,
    // Branch comparisons
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // Operand A source
  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_CURRPC,
    OP_A_ZERO
  } op_a_sel_e;

  // Operand B source
  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  // Immediate feeding operand B
  typedef enum logic [2:0] {
    IMM_B_I,
    IMM_B_S,
    IMM_B_B,
    IMM_B_U,
    IMM_B_J,
    IMM_B_INCR_PC
  } imm_b_sel_e;

  // Data access size
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  // ID-EX state
  typedef enum logic {
    FIRST_CYCLE,
    MULTI_CYCLE
  } id_fsm_e;

endpackage

// ==== rtl/id_decoder.sv ====
/*
 * RV32I decoder: field extraction, immediates, control decode
 * and the illegal-instruction check
 */
`timescale 1ns/100ps

module id_decoder import rv_isa_pkg::*, id_ctrl_pkg::*; (
  input  logic [XLEN-1:0]       instr_rdata_i,
  input  logic                  instr_first_cycle_i,
  output logic                  illegal_insn_o,
  // Register file
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic                  rf_ren_a_o,
  output logic                  rf_ren_b_o,
  output logic                  rf_we_o,
  // ALU and operand selects
  output alu_op_e               alu_operator_o,
  output op_a_sel_e             op_a_sel_o,
  output op_b_sel_e             op_b_sel_o,
  output imm_b_sel_e            imm_b_sel_o,
  // Immediates
  output logic [XLEN-1:0]       imm_i_o,
  output logic [XLEN-1:0]       imm_s_o,
  output logic [XLEN-1:0]       imm_b_o,
  output logic [XLEN-1:0]       imm_u_o,
  output logic [XLEN-1:0]       imm_j_o,
  // LSU
  output logic                  lsu_req_o,
  output logic                  lsu_we_o,
  output lsu_type_e             lsu_type_o,
  output logic                  lsu_sign_ext_o,
  // Control flow
  output logic                  branch_in_dec_o,
  output logic                  jump_in_dec_o
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  opcode_e    opcode;
  alu_op_e    alu_base;

  assign opcode = opcode_e'(instr_rdata_i[6:0]);
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  // Register addresses sit at fixed positions
  assign rf_raddr_a_o = instr_rdata_i[19:15];
  assign rf_raddr_b_o = instr_rdata_i[24:20];
  assign rf_waddr_o   = instr_rdata_i[11:7];

  ////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////

  assign imm_i_o = {{(XLEN-12){instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_s_o = {{(XLEN-12){instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
  // B and J keep bit 0 clear
  assign imm_b_o = {{(XLEN-12){instr_rdata_i[31]}}, instr_rdata_i[7], instr_rdata_i[30:25],
                    instr_rdata_i[11:8], 1'b0};
  assign imm_u_o = {instr_rdata_i[31:12], 12'b0};
  assign imm_j_o = {{(XLEN-20){instr_rdata_i[31]}}, instr_rdata_i[19:12], instr_rdata_i[20],
                    instr_rdata_i[30:21], 1'b0};

  // Plain ALU function shared by OP and OP-IMM
  always_comb begin
    unique case (funct3)
      FUNCT3_ADD:  alu_base = ALU_ADD;
      FUNCT3_SLL:  alu_base = ALU_SLL;
      FUNCT3_SLT:  alu_base = ALU_SLT;
      FUNCT3_SLTU: alu_base = ALU_SLTU;
      FUNCT3_XOR:  alu_base = ALU_XOR;
      FUNCT3_SR:   alu_base = ALU_SRL;
      FUNCT3_OR:   alu_base = ALU_OR;
      FUNCT3_AND:  alu_base = ALU_AND;
      default:     alu_base = ALU_ADD;
    endcase
  end

  ////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////

  always_comb begin
    illegal_insn_o  = 1'b0;
    rf_ren_a_o      = 1'b0;
    rf_ren_b_o      = 1'b0;
    rf_we_o         = 1'b0;
    alu_operator_o  = ALU_ADD;
    op_a_sel_o      = OP_A_REG_A;
    op_b_sel_o      = OP_B_IMM;
    imm_b_sel_o     = IMM_B_I;
    lsu_req_o       = 1'b0;
    lsu_we_o        = 1'b0;
    lsu_type_o      = LSU_WORD;
    lsu_sign_ext_o  = 1'b0;
    branch_in_dec_o = 1'b0;
    jump_in_dec_o   = 1'b0;

    unique case (opcode)
      OPCODE_JAL, OPCODE_JALR: begin
        jump_in_dec_o = 1'b1;
        if (instr_first_cycle_i) begin
          // Target: PC + J, or rs1 + I for JALR
          if (opcode == OPCODE_JALR) begin
            rf_ren_a_o  = 1'b1;
            illegal_insn_o = (funct3 != FUNCT3_JALR);
          end else begin
            op_a_sel_o  = OP_A_CURRPC;
            imm_b_sel_o = IMM_B_J;
          end
        end else begin
          // Link address into rd
          op_a_sel_o  = OP_A_CURRPC;
          imm_b_sel_o = IMM_B_INCR_PC;
          rf_we_o     = 1'b1;
        end
      end

      OPCODE_BRANCH: begin
        branch_in_dec_o = 1'b1;
        if (instr_first_cycle_i) begin
          // Condition from the two registers
          rf_ren_a_o = 1'b1;
          rf_ren_b_o = 1'b1;
          op_b_sel_o = OP_B_REG_B;
          unique case (funct3)
            FUNCT3_BEQ:  alu_operator_o = ALU_EQ;
            FUNCT3_BNE:  alu_operator_o = ALU_NE;
            FUNCT3_BLT:  alu_operator_o = ALU_LT;
            FUNCT3_BGE:  alu_operator_o = ALU_GE;
            FUNCT3_BLTU: alu_operator_o = ALU_LTU;
            FUNCT3_BGEU: alu_operator_o = ALU_GEU;
            default:     illegal_insn_o = 1'b1;
          endcase
        end else begin
          // Target in the second cycle
          op_a_sel_o  = OP_A_CURRPC;
          imm_b_sel_o = IMM_B_B;
        end
      end

      OPCODE_LOAD, OPCODE_STORE: begin
        lsu_req_o  = 1'b1;
        rf_ren_a_o = 1'b1;
        if (opcode == OPCODE_STORE) begin
          lsu_we_o    = 1'b1;
          rf_ren_b_o  = 1'b1;
          imm_b_sel_o = IMM_B_S;
          illegal_insn_o = funct3[2];
        end else begin
          rf_we_o        = 1'b1;
          lsu_sign_ext_o = ~funct3[2];
        end
        unique case (funct3)
          FUNCT3_LB, FUNCT3_LBU: lsu_type_o = LSU_BYTE;
          FUNCT3_LH, FUNCT3_LHU: lsu_type_o = LSU_HALF;
          FUNCT3_LW:             lsu_type_o = LSU_WORD;
          default:               illegal_insn_o = 1'b1;
        endcase
      end

      OPCODE_LUI, OPCODE_AUIPC: begin
        op_a_sel_o  = (opcode == OPCODE_LUI) ? OP_A_ZERO : OP_A_CURRPC;
        imm_b_sel_o = IMM_B_U;
        rf_we_o     = 1'b1;
      end

      OPCODE_OP_IMM: begin
        rf_ren_a_o     = 1'b1;
        rf_we_o        = 1'b1;
        alu_operator_o = alu_base;
        // Shift amounts carry funct7 in the upper immediate bits
        if (funct3 == FUNCT3_SLL) begin
          illegal_insn_o = (funct7 != 7'b0);
        end else if (funct3 == FUNCT3_SR) begin
          if (funct7 == 7'b0100000) begin
            alu_operator_o = ALU_SRA;
          end else begin
            illegal_insn_o = (funct7 != 7'b0);
          end
        end
      end

      OPCODE_OP: begin
        rf_ren_a_o = 1'b1;
        rf_ren_b_o = 1'b1;
        rf_we_o    = 1'b1;
        op_b_sel_o = OP_B_REG_B;
        if (funct7 == 7'b0) begin
          alu_operator_o = alu_base;
        end else if (funct7 == 7'b0100000 && funct3 == FUNCT3_ADD) begin
          alu_operator_o = ALU_SUB;
        end else if (funct7 == 7'b0100000 && funct3 == FUNCT3_SR) begin
          alu_operator_o = ALU_SRA;
        end else begin
          illegal_insn_o = 1'b1;
        end
      end

      default: illegal_insn_o = 1'b1;
    endcase

    // Illegal encodings have no side effects
    if (illegal_insn_o) begin
      rf_ren_a_o      = 1'b0;
      rf_ren_b_o      = 1'b0;
      rf_we_o         = 1'b0;
      lsu_req_o       = 1'b0;
      branch_in_dec_o = 1'b0;
      jump_in_dec_o   = 1'b0;
    end
  end

endmodule

// ==== rtl/id_ex_fsm.sv ====
/*
 * ID-EX first/multi-cycle FSM: memory, branch and jump stalls,
 * single pc_set pulse per instruction and instruction done
 */
`timescale 1ns/100ps

module id_ex_fsm import id_ctrl_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic instr_valid_i,
  input  logic lsu_req_dec_i,
  input  logic branch_in_dec_i,
  input  logic jump_in_dec_i,
  input  logic rf_we_dec_i,
  input  logic branch_decision_i,
  input  logic lsu_resp_valid_i,
  output logic instr_first_cycle_o,
  output logic lsu_req_o,
  output logic rf_we_o,
  output logic pc_set_o,
  output logic instr_done_o
);

  id_fsm_e id_fsm_q, id_fsm_d;
  logic    instr_executing;
  logic    instr_first_cycle;
  logic    multicycle_done;
  logic    stall_mem, stall_branch, stall_jump;
  logic    branch_set_raw_d, branch_set_raw_q;
  logic    jump_set_raw;
  logic    set_done_d, set_done_q;

  // No controller, so any valid instruction executes
  assign instr_executing   = instr_valid_i;
  assign instr_first_cycle = instr_valid_i & (id_fsm_q == FIRST_CYCLE);

  // Load/store always stalls its first cycle, then waits for the response
  assign stall_mem       = instr_valid_i & lsu_req_dec_i & (~lsu_resp_valid_i | instr_first_cycle);
  assign multicycle_done = ~lsu_req_dec_i | lsu_resp_valid_i;

  ////////////////////////////////////////
  // State transitions
  ////////////////////////////////////////

  always_comb begin
    id_fsm_d         = id_fsm_q;
    stall_branch     = 1'b0;
    stall_jump       = 1'b0;
    branch_set_raw_d = 1'b0;
    jump_set_raw     = 1'b0;

    if (instr_executing) begin
      unique case (id_fsm_q)
        FIRST_CYCLE: begin
          unique case (1'b1)
            lsu_req_dec_i: id_fsm_d = MULTI_CYCLE;
            branch_in_dec_i: begin
              // Taken branch computes its target next cycle
              id_fsm_d         = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
              stall_branch     = branch_decision_i;
              branch_set_raw_d = branch_decision_i;
            end
            jump_in_dec_i: begin
              // Target now, link address next cycle
              id_fsm_d     = MULTI_CYCLE;
              stall_jump   = 1'b1;
              jump_set_raw = 1'b1;
            end
            default: id_fsm_d = FIRST_CYCLE;
          endcase
        end
        MULTI_CYCLE: begin
          if (multicycle_done) begin
            id_fsm_d = FIRST_CYCLE;
          end else begin
            stall_branch = branch_in_dec_i;
            stall_jump   = jump_in_dec_i;
          end
        end
        default: id_fsm_d = FIRST_CYCLE;
      endcase
    end
  end

  // Branch set goes out in the cycle after the condition
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q         <= FIRST_CYCLE;
      branch_set_raw_q <= 1'b0;
      set_done_q       <= 1'b0;
    end else begin
      if (instr_executing) begin
        id_fsm_q <= id_fsm_d;
      end
      branch_set_raw_q <= branch_set_raw_d;
      set_done_q       <= set_done_d;
    end
  end

  // Remember a set already issued until the instruction leaves
  assign set_done_d = (branch_set_raw_q | jump_set_raw | set_done_q) & ~instr_done_o;
  assign pc_set_o   = (branch_set_raw_q | jump_set_raw) & ~set_done_q;

  assign instr_done_o        = instr_executing & ~(stall_mem | stall_branch | stall_jump);
  assign instr_first_cycle_o = instr_first_cycle;
  assign lsu_req_o           = instr_executing & lsu_req_dec_i & instr_first_cycle;
  assign rf_we_o             = instr_executing & rf_we_dec_i;

endmodule

// ==== rtl/id_operand_mux.sv ====
/*
 * ALU operand multiplexers with the operand B immediate select
 */
`timescale 1ns/100ps

module id_operand_mux import rv_isa_pkg::*, id_ctrl_pkg::*; (
  input  op_a_sel_e       op_a_sel_i,
  input  op_b_sel_e       op_b_sel_i,
  input  imm_b_sel_e      imm_b_sel_i,
  input  logic [XLEN-1:0] imm_i_i,
  input  logic [XLEN-1:0] imm_s_i,
  input  logic [XLEN-1:0] imm_b_i,
  input  logic [XLEN-1:0] imm_u_i,
  input  logic [XLEN-1:0] imm_j_i,
  input  logic [XLEN-1:0] rf_rdata_a_i,
  input  logic [XLEN-1:0] rf_rdata_b_i,
  input  logic [XLEN-1:0] pc_id_i,
  output logic [XLEN-1:0] alu_operand_a_o,
  output logic [XLEN-1:0] alu_operand_b_o
);

  logic [XLEN-1:0] imm_b_mux;

  // Operand B immediate, the increment is a fixed word step
  always_comb begin
    unique case (imm_b_sel_i)
      IMM_B_I:       imm_b_mux = imm_i_i;
      IMM_B_S:       imm_b_mux = imm_s_i;
      IMM_B_B:       imm_b_mux = imm_b_i;
      IMM_B_U:       imm_b_mux = imm_u_i;
      IMM_B_J:       imm_b_mux = imm_j_i;
      IMM_B_INCR_PC: imm_b_mux = XLEN'(INSTR_INCR);
      default:       imm_b_mux = XLEN'(INSTR_INCR);
    endcase
  end

  // Operand A
  always_comb begin
    unique case (op_a_sel_i)
      OP_A_REG_A:  alu_operand_a_o = rf_rdata_a_i;
      OP_A_CURRPC: alu_operand_a_o = pc_id_i;
      OP_A_ZERO:   alu_operand_a_o = '0;
      default:     alu_operand_a_o = pc_id_i;
    endcase
  end

  // Operand B
  assign alu_operand_b_o = (op_b_sel_i == OP_B_IMM) ? imm_b_mux : rf_rdata_b_i;

endmodule

// ==== rtl/id_stage.sv ====
/*
 * RV32I decode stage top: decoder, operand mux and ID-EX FSM
 */
`timescale 1ns/100ps

module id_stage import rv_isa_pkg::*, id_ctrl_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Instruction from IF
  input  logic                  instr_valid_i,
  input  logic [XLEN-1:0]       instr_rdata_i,
  input  logic [XLEN-1:0]       pc_id_i,
  // EX and LSU feedback
  input  logic                  branch_decision_i,
  input  logic                  lsu_resp_valid_i,
  // Register file
  input  logic [XLEN-1:0]       rf_rdata_a_i,
  input  logic [XLEN-1:0]       rf_rdata_b_i,
  output logic                  illegal_insn_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic                  rf_ren_a_o,
  output logic                  rf_ren_b_o,
  output logic                  rf_we_o,
  // ALU
  output alu_op_e               alu_operator_o,
  output logic [XLEN-1:0]       alu_operand_a_o,
  output logic [XLEN-1:0]       alu_operand_b_o,
  // LSU
  output logic                  lsu_req_o,
  output logic                  lsu_we_o,
  output lsu_type_e             lsu_type_o,
  output logic                  lsu_sign_ext_o,
  output logic [XLEN-1:0]       lsu_wdata_o,
  // Pipeline control
  output logic                  pc_set_o,
  output logic                  instr_first_cycle_o,
  output logic                  instr_id_done_o,
  output logic                  id_in_ready_o
);

  op_a_sel_e       op_a_sel;
  op_b_sel_e       op_b_sel;
  imm_b_sel_e      imm_b_sel;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic            lsu_req_dec, branch_in_dec, jump_in_dec, rf_we_dec;
  logic            instr_done;

  ////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////

  id_decoder u_decoder (
    .instr_rdata_i      (instr_rdata_i),
    .instr_first_cycle_i(instr_first_cycle_o),
    .illegal_insn_o     (illegal_insn_o),
    .rf_raddr_a_o       (rf_raddr_a_o),
    .rf_raddr_b_o       (rf_raddr_b_o),
    .rf_waddr_o         (rf_waddr_o),
    .rf_ren_a_o         (rf_ren_a_o),
    .rf_ren_b_o         (rf_ren_b_o),
    .rf_we_o            (rf_we_dec),
    .alu_operator_o     (alu_operator_o),
    .op_a_sel_o         (op_a_sel),
    .op_b_sel_o         (op_b_sel),
    .imm_b_sel_o        (imm_b_sel),
    .imm_i_o            (imm_i),
    .imm_s_o            (imm_s),
    .imm_b_o            (imm_b),
    .imm_u_o            (imm_u),
    .imm_j_o            (imm_j),
    .lsu_req_o          (lsu_req_dec),
    .lsu_we_o           (lsu_we_o),
    .lsu_type_o         (lsu_type_o),
    .lsu_sign_ext_o     (lsu_sign_ext_o),
    .branch_in_dec_o    (branch_in_dec),
    .jump_in_dec_o      (jump_in_dec)
  );

  ////////////////////////////////////////
  // Operands
  ////////////////////////////////////////

  id_operand_mux u_operand_mux (
    .op_a_sel_i     (op_a_sel),
    .op_b_sel_i     (op_b_sel),
    .imm_b_sel_i    (imm_b_sel),
    .imm_i_i        (imm_i),
    .imm_s_i        (imm_s),
    .imm_b_i        (imm_b),
    .imm_u_i        (imm_u),
    .imm_j_i        (imm_j),
    .rf_rdata_a_i   (rf_rdata_a_i),
    .rf_rdata_b_i   (rf_rdata_b_i),
    .pc_id_i        (pc_id_i),
    .alu_operand_a_o(alu_operand_a_o),
    .alu_operand_b_o(alu_operand_b_o)
  );

  ////////////////////////////////////////
  // ID-EX FSM
  ////////////////////////////////////////

  id_ex_fsm u_fsm (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .instr_valid_i      (instr_valid_i),
    .lsu_req_dec_i      (lsu_req_dec),
    .branch_in_dec_i    (branch_in_dec),
    .jump_in_dec_i      (jump_in_dec),
    .rf_we_dec_i        (rf_we_dec),
    .branch_decision_i  (branch_decision_i),
    .lsu_resp_valid_i   (lsu_resp_valid_i),
    .instr_first_cycle_o(instr_first_cycle_o),
    .lsu_req_o          (lsu_req_o),
    .rf_we_o            (rf_we_o),
    .pc_set_o           (pc_set_o),
    .instr_done_o       (instr_done)
  );

  // Store data straight from register B, no forwarding
  assign lsu_wdata_o = rf_rdata_b_i;

  // Without a writeback stage, done also frees the stage
  assign instr_id_done_o = instr_done;
  assign id_in_ready_o   = instr_done;

endmodule

// ==== rtl/rv_isa_pkg.sv ====
/*
 * RV32I instruction-set constants: widths, PC increment,
 * the major opcode type and the function-3 codes
 */
package rv_isa_pkg;

  // Datapath and register file widths
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // No compressed instructions, so the PC always steps by a word
  localparam int unsigned INSTR_INCR = 4;

  // Major opcodes kept by the reduced decoder
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

  // Branch conditions
  localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
  localparam logic [2:0] FUNCT3_BNE  = 3'b001;
  localparam logic [2:0] FUNCT3_BLT  = 3'b100;
  localparam logic [2:0] FUNCT3_BGE  = 3'b101;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;
  localparam logic [2:0] FUNCT3_BGEU = 3'b111;

  // Load/store sizes, stores reuse the signed codes
  localparam logic [2:0] FUNCT3_LB   = 3'b000;
  localparam logic [2:0] FUNCT3_LH   = 3'b001;
  localparam logic [2:0] FUNCT3_LW   = 3'b010;
  localparam logic [2:0] FUNCT3_LBU  = 3'b100;
  localparam logic [2:0] FUNCT3_LHU  = 3'b101;

  // Integer ALU functions and JALR
  localparam logic [2:0] FUNCT3_ADD  = 3'b000;
  localparam logic [2:0] FUNCT3_SLL  = 3'b001;
  localparam logic [2:0] FUNCT3_SLT  = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU = 3'b011;
  localparam logic [2:0] FUNCT3_XOR  = 3'b100;
  localparam logic [2:0] FUNCT3_SR   = 3'b101;
  localparam logic [2:0] FUNCT3_OR   = 3'b110;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;
  localparam logic [2:0] FUNCT3_JALR = 3'b000;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module tb_id_stage -o sim_id_stage
out=$(./obj_dir/sim_id_stage)
echo "$out"
if echo "$out" | grep -q 'All tests passed!'; then
  exit 0
fi
exit 1

// ==== verif/id_stage_properties.sv ====
/*
 * Concurrent protocol assertions on the decode stage top,
 * attached to id_stage with bind
 */
`timescale 1ns/100ps

module id_stage_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic instr_valid_i,
  input logic lsu_req_i,
  input logic instr_first_cycle_i,
  input logic pc_set_i,
  input logic illegal_insn_i,
  input logic rf_we_i,
  input logic instr_done_i
);

  // Memory request only in the first cycle of an instruction
  a_req_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_i |-> instr_first_cycle_i) else $error("lsu_req_o outside first cycle");

  // A PC set is a single-cycle pulse
  a_set_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |=> !pc_set_i) else $error("pc_set_o high for two cycles");

  // Illegal encodings have no side effects
  a_illegal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_insn_i |-> (!rf_we_i && !lsu_req_i)) else $error("illegal insn with side effect");

  a_done_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_done_i |-> instr_valid_i) else $error("done without a valid instruction");

endmodule

bind id_stage id_stage_properties u_props (
  .clk_i              (clk_i),
  .rst_ni             (rst_ni),
  .instr_valid_i      (instr_valid_i),
  .lsu_req_i          (lsu_req_o),
  .instr_first_cycle_i(instr_first_cycle_o),
  .pc_set_i           (pc_set_o),
  .illegal_insn_i     (illegal_insn_o),
  .rf_we_i            (rf_we_o),
  .instr_done_i       (instr_id_done_o)
);

// ==== verif/tb_id_stage.sv ====
/*
 * Decode stage testbench: clock, reset, register file and LSU models,
 * stimulus table with expected values, compare tasks and report
 */
`timescale 1ns/100ps

module tb_id_stage import rv_isa_pkg::*, id_ctrl_pkg::*; ();

  typedef enum logic [3:0] {
    K_RR, K_RI, K_LUI, K_AUIPC, K_LOAD, K_STORE, K_BR, K_JAL, K_JALR, K_ILL
  } kind_e;

  // One table row: stimulus, then the expected decode
  typedef struct packed {
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
    logic            taken;
    logic [3:0]      dly;
    kind_e           kind;
    alu_op_e         op;
    logic [XLEN-1:0] imm;
    lsu_type_e       ltype;
    logic            sext;
  } entry_t;

  localparam int N_TESTS = 18;
  localparam int MAX_DLY = 6;
  localparam int LIMIT   = N_TESTS * (MAX_DLY + 4) + 20;

  logic clk_i, rst_ni, instr_valid, branch_decision, lsu_resp_valid;
  logic [XLEN-1:0] instr_rdata, pc_id, rf_rdata_a, rf_rdata_b;
  logic illegal_insn, rf_ren_a, rf_ren_b, rf_we, lsu_req, lsu_we, lsu_sign_ext;
  logic pc_set, instr_first_cycle, instr_id_done, id_in_ready;
  logic [REG_ADDR_W-1:0] rf_raddr_a, rf_raddr_b, rf_waddr;
  logic [XLEN-1:0] alu_operand_a, alu_operand_b, lsu_wdata;
  alu_op_e   alu_operator;
  lsu_type_e lsu_type;

  logic [XLEN-1:0] regs [32];
  logic [XLEN-1:0] rnd;
  entry_t tbl [N_TESTS];
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int cur_dly;

  id_stage DUT (
    .clk_i(clk_i), .rst_ni(rst_ni), .instr_valid_i(instr_valid),
    .instr_rdata_i(instr_rdata), .pc_id_i(pc_id), .branch_decision_i(branch_decision),
    .lsu_resp_valid_i(lsu_resp_valid), .rf_rdata_a_i(rf_rdata_a), .rf_rdata_b_i(rf_rdata_b),
    .illegal_insn_o(illegal_insn), .rf_raddr_a_o(rf_raddr_a), .rf_raddr_b_o(rf_raddr_b),
    .rf_waddr_o(rf_waddr), .rf_ren_a_o(rf_ren_a), .rf_ren_b_o(rf_ren_b), .rf_we_o(rf_we),
    .alu_operator_o(alu_operator), .alu_operand_a_o(alu_operand_a),
    .alu_operand_b_o(alu_operand_b), .lsu_req_o(lsu_req), .lsu_we_o(lsu_we),
    .lsu_type_o(lsu_type), .lsu_sign_ext_o(lsu_sign_ext), .lsu_wdata_o(lsu_wdata),
    .pc_set_o(pc_set), .instr_first_cycle_o(instr_first_cycle),
    .instr_id_done_o(instr_id_done), .id_in_ready_o(id_in_ready)
  );

  // Register file answers the read addresses combinationally
  assign rf_rdata_a = regs[rf_raddr_a];
  assign rf_rdata_b = regs[rf_raddr_b];

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Run limit from the table length and the longest LSU delay
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_op(input alu_op_e got, input alu_op_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL alu_operator_o got %h expected %h", got, exp);
    end
  endtask

  task automatic check_type(input lsu_type_e got, input lsu_type_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL lsu_type_o got %h expected %h", got, exp);
    end
  endtask

  // Expected outputs of one entry in its cycle c
  task automatic check_cycle(input entry_t e, input int c);
    logic [XLEN-1:0] a, b;
    logic is_jal;
    logic is_mem;
    logic done_exp;
    logic ren_a_exp;
    logic ren_b_exp;
    a = regs[e.instr[19:15]];
    b = regs[e.instr[24:20]];
    is_jal = (e.kind == K_JAL);
    is_mem = (e.kind == K_LOAD) || (e.kind == K_STORE);
    case (e.kind)
      K_RR, K_RI, K_LUI, K_AUIPC: begin
        done_exp  = 1'b1;
        ren_a_exp = (e.kind == K_RR) || (e.kind == K_RI);
        ren_b_exp = (e.kind == K_RR);
        check_op(alu_operator, e.op);
        check_word("alu_operand_a_o", alu_operand_a,
                   (e.kind == K_LUI) ? '0 : (e.kind == K_AUIPC) ? e.pc : a);
        check_word("alu_operand_b_o", alu_operand_b, (e.kind == K_RR) ? b : e.imm);
        check_bit("rf_we_o", rf_we, 1'b1);
        check_word("rf_waddr_o", XLEN'(rf_waddr), XLEN'(e.instr[11:7]));
        check_bit("pc_set_o", pc_set, 1'b0);
      end
      K_LOAD, K_STORE: begin
        done_exp  = (c == cur_dly);
        ren_a_exp = 1'b1;
        ren_b_exp = (e.kind == K_STORE);
        check_op(alu_operator, e.op);
        check_word("alu_operand_a_o", alu_operand_a, a);
        check_word("alu_operand_b_o", alu_operand_b, e.imm);
        check_type(lsu_type, e.ltype);
        check_bit("lsu_sign_ext_o", lsu_sign_ext, e.sext);
        check_bit("lsu_we_o", lsu_we, e.kind == K_STORE);
        check_bit("rf_we_o", rf_we, e.kind == K_LOAD);
        if (e.kind == K_STORE) check_word("lsu_wdata_o", lsu_wdata, b);
      end
      K_BR: begin
        done_exp  = (c == 1) || !e.taken;
        ren_a_exp = (c == 0);
        ren_b_exp = (c == 0);
        // Condition first, target in the second cycle
        check_op(alu_operator, (c == 0) ? e.op : ALU_ADD);
        check_word("alu_operand_a_o", alu_operand_a, (c == 0) ? a : e.pc);
        check_word("alu_operand_b_o", alu_operand_b, (c == 0) ? b : e.imm);
        check_bit("pc_set_o", pc_set, c == 1);
        check_bit("rf_we_o", rf_we, 1'b0);
      end
      K_JAL, K_JALR: begin
        done_exp  = (c == 1);
        ren_a_exp = !is_jal && (c == 0);
        ren_b_exp = 1'b0;
        check_op(alu_operator, ALU_ADD);
        check_word("alu_operand_a_o", alu_operand_a, (c > 0 || is_jal) ? e.pc : a);
        check_word("alu_operand_b_o", alu_operand_b, (c == 0) ? e.imm : XLEN'(INSTR_INCR));
        check_bit("pc_set_o", pc_set, c == 0);
        check_bit("rf_we_o", rf_we, c == 1);
      end
      default: begin
        done_exp  = 1'b1;
        ren_a_exp = 1'b0;
        ren_b_exp = 1'b0;
        check_bit("rf_we_o", rf_we, 1'b0);
      end
    endcase
    // Shared by every kind
    check_bit("illegal_insn_o", illegal_insn, e.kind == K_ILL);
    check_bit("instr_first_cycle_o", instr_first_cycle, c == 0);
    check_bit("lsu_req_o", lsu_req, is_mem && (c == 0));
    check_bit("rf_ren_a_o", rf_ren_a, ren_a_exp);
    check_bit("rf_ren_b_o", rf_ren_b, ren_b_exp);
    check_bit("instr_id_done_o", instr_id_done, done_exp);
    check_bit("id_in_ready_o", id_in_ready, done_exp);
  endtask

  // Present one entry and hold it until the stage is ready
  task automatic run_test(input int i);
    entry_t e;
    int c;
    int errs0;
    logic done_seen;
    e = tbl[i];
    errs0 = errors;
    cur_dly = 0;
    if (e.dly != 0) begin
      rnd = xorshift(rnd);
      cur_dly = 1 + int'(rnd % XLEN'(e.dly));
    end
    @(posedge clk_i);
    instr_valid     <= 1'b1;
    instr_rdata     <= e.instr;
    pc_id           <= e.pc;
    branch_decision <= e.taken;
    lsu_resp_valid  <= 1'b0;
    c = 0;
    done_seen = 1'b0;
    while (!done_seen) begin
      @(negedge clk_i);
      check_cycle(e, c);
      done_seen = instr_id_done;
      if (!done_seen) begin
        @(posedge clk_i);
        lsu_resp_valid <= (c + 1 == cur_dly);
        c++;
      end
    end
    @(posedge clk_i);
    instr_valid    <= 1'b0;
    lsu_resp_valid <= 1'b0;
    $display("test %0d %s: %s", i, e.kind.name(), (errors == errs0) ? "ok" : "mismatch");
  endtask

  initial begin
    instr_valid     = 1'b0;
    instr_rdata     = '0;
    pc_id           = '0;
    branch_decision = 1'b0;
    lsu_resp_valid  = 1'b0;
    rst_ni          = 1'b0;
    // Register contents from the xorshift sequence, x0 reads zero
    rnd = 32'hbaef_2219;
    for (int n = 0; n < 32; n++) begin
      rnd = xorshift(rnd);
      regs[n] = (n == 0) ? '0 : rnd;
    end
    ////////////////////////////////////////
    // instr, pc, taken, max delay, kind, op, imm, size, sign ext
    tbl[0]  = '{32'h002081B3, 32'h1000, 1'b0, 4'd0, K_RR, ALU_ADD, 32'h0, LSU_WORD, 1'b0};
    tbl[1]  = '{32'h40730233, 32'h1004, 1'b0, 4'd0, K_RR, ALU_SUB, 32'h0, LSU_WORD, 1'b0};
    tbl[2]  = '{32'h409452B3, 32'h1008, 1'b0, 4'd0, K_RR, ALU_SRA, 32'h0, LSU_WORD, 1'b0};
    tbl[3]  = '{32'hFFB58513, 32'h100C, 1'b0, 4'd0, K_RI, ALU_ADD, 32'hFFFFFFFB, LSU_WORD, 1'b0};
    tbl[4]  = '{32'h07F6C613, 32'h1010, 1'b0, 4'd0, K_RI, ALU_XOR, 32'h7F, LSU_WORD, 1'b0};
    tbl[5]  = '{32'hABCDE737, 32'h1014, 1'b0, 4'd0, K_LUI, ALU_ADD, 32'hABCDE000, LSU_WORD, 1'b0};
    tbl[6]  = '{32'h12345797, 32'h1018, 1'b0, 4'd0, K_AUIPC, ALU_ADD, 32'h12345000, LSU_WORD, 1'b0};
    tbl[7]  = '{32'h0088A803, 32'h101C, 1'b0, 4'd6, K_LOAD, ALU_ADD, 32'h8, LSU_WORD, 1'b1};
    tbl[8]  = '{32'hFFF9C903, 32'h1020, 1'b0, 4'd6, K_LOAD, ALU_ADD, 32'hFFFFFFFF, LSU_BYTE, 1'b0};
    tbl[9]  = '{32'h014AA623, 32'h1024, 1'b0, 4'd6, K_STORE, ALU_ADD, 32'hC, LSU_WORD, 1'b0};
    tbl[10] = '{32'hFF6B9E23, 32'h1028, 1'b0, 4'd6, K_STORE, ALU_ADD, 32'hFFFFFFFC, LSU_HALF, 1'b0};
    tbl[11] = '{32'h00208863, 32'h102C, 1'b0, 4'd0, K_BR, ALU_EQ, 32'h10, LSU_WORD, 1'b0};
    tbl[12] = '{32'hFE419CE3, 32'h1030, 1'b1, 4'd0, K_BR, ALU_NE, 32'hFFFFFFF8, LSU_WORD, 1'b0};
    tbl[13] = '{32'h0262E063, 32'h1034, 1'b1, 4'd0, K_BR, ALU_LTU, 32'h20, LSU_WORD, 1'b0};
    tbl[14] = '{32'h001000EF, 32'h1038, 1'b0, 4'd0, K_JAL, ALU_ADD, 32'h800, LSU_WORD, 1'b0};
    tbl[15] = '{32'h004380E7, 32'h103C, 1'b0, 4'd0, K_JALR, ALU_ADD, 32'h4, LSU_WORD, 1'b0};
    tbl[16] = '{32'hFFFFFFFF, 32'h1040, 1'b0, 4'd0, K_ILL, ALU_ADD, 32'h0, LSU_WORD, 1'b0};
    tbl[17] = '{32'h02208133, 32'h1044, 1'b0, 4'd0, K_ILL, ALU_ADD, 32'h0, LSU_WORD, 1'b0};
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Idle stage after reset
    @(negedge clk_i);
    check_bit("instr_id_done_o", instr_id_done, 1'b0);
    check_bit("id_in_ready_o", id_in_ready, 1'b0);
    check_bit("lsu_req_o", lsu_req, 1'b0);
    check_bit("rf_we_o", rf_we, 1'b0);
    check_bit("pc_set_o", pc_set, 1'b0);
    for (int i = 0; i < N_TESTS; i++) begin
      run_test(i);
    end
    $display("%0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
